/* fifo_pkg.sv */
package fifo_pkg;

    // ******************************
    // Storage geometry
    // ******************************
    localparam int data_width    = 8;
    localparam int fifo_depth    = 16;
    localparam int addr_width    = 4;
    localparam int cnt_width     = 5;   // Holds 0 to fifo_depth inclusive
    localparam int err_cnt_width = 8;

    // ******************************
    // Register map
    // ******************************
    localparam int reg_addr_width = 2;
    localparam int reg_data_width = 16;

    localparam logic [reg_addr_width-1:0] reg_afull  = 2'd0;
    localparam logic [reg_addr_width-1:0] reg_aempty = 2'd1;
    localparam logic [reg_addr_width-1:0] reg_status = 2'd2;
    localparam logic [reg_addr_width-1:0] reg_errors = 2'd3;

    localparam logic [cnt_width-1:0] afull_reset  = 5'd15;
    localparam logic [cnt_width-1:0] aempty_reset = 5'd1;

endpackage

/* fifo_cfg_if.sv */
interface fifo_cfg_if;
    import fifo_pkg::*;

    logic [cnt_width-1:0] afull_level;
    logic [cnt_width-1:0] aempty_level;
    logic [cnt_width-1:0] count;
    logic                 empty;
    logic                 almost_empty;
    logic                 almost_full;
    logic                 full;
    logic                 overflow;      // Rejected write in this cycle
    logic                 underflow;     // Rejected read in this cycle

    modport fifo_side (
        input  afull_level, aempty_level,
        output count, empty, almost_empty, almost_full, full,
        output overflow, underflow
    );

    modport reg_side (
        output afull_level, aempty_level,
        input  count, empty, almost_empty, almost_full, full,
        input  overflow, underflow
    );

endinterface

/* sync_fifo.sv */
module sync_fifo (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr_en,
    input  logic [fifo_pkg::data_width-1:0] wr_data,
    input  logic                            rd_en,
    output logic [fifo_pkg::data_width-1:0] rd_data,
    fifo_cfg_if.fifo_side                   cfg
);
    import fifo_pkg::*;

    logic [data_width-1:0] mem [fifo_depth];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [cnt_width-1:0]  count;
    logic                  full;
    logic                  empty;
    logic                  wr_ok;
    logic                  rd_ok;

    // Step a pointer forward and fold it back to zero past the last entry
    function automatic logic [addr_width-1:0] next_ptr(input logic [addr_width-1:0] ptr);
        logic [addr_width-1:0] nxt;
        if (ptr == addr_width'(fifo_depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // ******************************
    // Acceptance
    // ******************************
    assign full  = (count == cnt_width'(fifo_depth));
    assign empty = (count == '0);

    // Both strobes are judged on the flags before the edge
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // ******************************
    // Storage and pointers
    // ******************************
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or a write and a read together
            endcase
        end
    end

    // Oldest entry is captured on an accepted read and held until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // ******************************
    // Status towards the registers
    // ******************************
    assign cfg.count        = count;
    assign cfg.full         = full;
    assign cfg.empty        = empty;
    assign cfg.almost_full  = (count >= cfg.afull_level);
    assign cfg.almost_empty = (count <= cfg.aempty_level);

    assign cfg.overflow  = wr_en && full;     // Dropped write
    assign cfg.underflow = rd_en && empty;    // Dropped read

endmodule

/* fifo_regs.sv */
module fifo_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                reg_wr,
    input  logic [fifo_pkg::reg_addr_width-1:0] reg_addr,
    input  logic [fifo_pkg::reg_data_width-1:0] reg_wdata,
    output logic [fifo_pkg::reg_data_width-1:0] reg_rdata,
    fifo_cfg_if.reg_side                        cfg
);
    import fifo_pkg::*;

    logic [cnt_width-1:0]      afull_level;
    logic [cnt_width-1:0]      aempty_level;
    logic [err_cnt_width-1:0]  ovf_cnt;
    logic [err_cnt_width-1:0]  unf_cnt;
    logic [reg_data_width-1:0] status_word;
    logic                      err_clr;

    // Counter step that sticks at all ones
    function automatic logic [err_cnt_width-1:0] sat_inc(
        input logic [err_cnt_width-1:0] cnt,
        input logic                     hit
    );
        logic [err_cnt_width-1:0] nxt;
        if (hit && (cnt != '1)) begin
            nxt = cnt + 1'b1;
        end else begin
            nxt = cnt;
        end
        return nxt;
    endfunction

    // ******************************
    // Thresholds
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            afull_level  <= afull_reset;
            aempty_level <= aempty_reset;
        end else if (reg_wr) begin
            if (reg_addr == reg_afull) begin
                afull_level <= reg_wdata[cnt_width-1:0];    // Upper bits are ignored
            end
            if (reg_addr == reg_aempty) begin
                aempty_level <= reg_wdata[cnt_width-1:0];
            end
        end
    end

    assign cfg.afull_level  = afull_level;
    assign cfg.aempty_level = aempty_level;

    // ******************************
    // Error counters
    // ******************************
    assign err_clr = reg_wr && (reg_addr == reg_errors);

    // A clear wins over a pulse arriving in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_cnt <= '0;
            unf_cnt <= '0;
        end else if (err_clr) begin
            ovf_cnt <= '0;
            unf_cnt <= '0;
        end else begin
            ovf_cnt <= sat_inc(ovf_cnt, cfg.overflow);
            unf_cnt <= sat_inc(unf_cnt, cfg.underflow);
        end
    end

    // ******************************
    // Read back
    // ******************************
    always_comb begin
        status_word                  = '0;
        status_word[cnt_width-1:0]   = cfg.count;
        status_word[8]               = cfg.empty;
        status_word[9]               = cfg.almost_empty;
        status_word[10]              = cfg.almost_full;
        status_word[11]              = cfg.full;
    end

    always_comb begin
        case (reg_addr)
            reg_afull:  reg_rdata = reg_data_width'(afull_level);
            reg_aempty: reg_rdata = reg_data_width'(aempty_level);
            reg_status: reg_rdata = status_word;
            reg_errors: reg_rdata = {unf_cnt, ovf_cnt};    // Underflows in the high byte
            default:    reg_rdata = '0;
        endcase
    end

endmodule

/* fifo_buffer_top.sv */
module fifo_buffer_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wr_en,
    input  logic [fifo_pkg::data_width-1:0]     wr_data,
    input  logic                                rd_en,
    output logic [fifo_pkg::data_width-1:0]     rd_data,
    output logic                                full,
    output logic                                empty,
    output logic                                almost_full,
    output logic                                almost_empty,
    output logic                                overflow,
    output logic                                underflow,
    input  logic                                reg_wr,
    input  logic [fifo_pkg::reg_addr_width-1:0] reg_addr,
    input  logic [fifo_pkg::reg_data_width-1:0] reg_wdata,
    output logic [fifo_pkg::reg_data_width-1:0] reg_rdata
);

    fifo_cfg_if cfg ();

    // ******************************
    // Data path
    // ******************************
    sync_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .cfg     (cfg.fifo_side)
    );

    // ******************************
    // Control registers
    // ******************************
    fifo_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .cfg       (cfg.reg_side)
    );

    // Status leaves the chip without any extra register stage
    assign full         = cfg.full;
    assign empty        = cfg.empty;
    assign almost_full  = cfg.almost_full;
    assign almost_empty = cfg.almost_empty;
    assign overflow     = cfg.overflow;
    assign underflow    = cfg.underflow;

endmodule

/* fifo_buffer_asserts.sv */
module fifo_buffer_asserts (
    input logic                            clk,
    input logic                            rst_n,
    input logic [fifo_pkg::cnt_width-1:0]  count,
    input logic [fifo_pkg::addr_width-1:0] wr_ptr,
    input logic [fifo_pkg::addr_width-1:0] rd_ptr,
    input logic                            full,
    input logic                            empty,
    input logic                            overflow
);
    timeunit 1ns;
    timeprecision 100ps;

    import fifo_pkg::*;

    // ******************************
    // Flag and count rules
    // ******************************
    // Equal pointers mean the buffer is either completely full or completely empty
    full_empty_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty) && ((full || empty) == (wr_ptr == rd_ptr)))
        else $error("full and empty disagree with each other or with the pointers");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_width'(fifo_depth))
        else $error("Occupancy count %0d is above the depth", count);

    // A dropped write only happens with the pointers level and leaves the write pointer alone
    overflow_needs_full: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |=> $stable(wr_ptr) && ($past(wr_ptr) == $past(rd_ptr)))
        else $error("overflow pulsed on a buffer that was not full or moved the write pointer");

endmodule

bind sync_fifo fifo_buffer_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .count    (count),
    .wr_ptr   (wr_ptr),
    .rd_ptr   (rd_ptr),
    .full     (full),
    .empty    (empty),
    .overflow (cfg.overflow)
);

/* tb_fifo_buffer.sv */
module tb_fifo_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    import fifo_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    logic        rd_en;
    logic        reg_wr;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        full;
    logic        empty;
    logic        almost_full;
    logic        almost_empty;
    logic        overflow;
    logic        underflow;
    logic [1:0]  reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;

    integer      seed;
    logic [31:0] rnd;
    logic [7:0]  model_q [$];    // Reference contents, oldest at the front
    logic [4:0]  m_afull;
    logic [4:0]  m_aempty;
    logic [7:0]  m_ovf;
    logic [7:0]  m_unf;
    logic [7:0]  exp_rd;

    fifo_buffer_top dut0 (.*);

    always #20 clk = ~clk;

    task automatic check_eq(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    // One clock of traffic, entered and left 2 ns after a rising edge
    task automatic run_cycle(input logic w, input logic [7:0] d, input logic r);
        logic [4:0] cnt;
        logic [5:0] exp_flags;
        logic       wr_ok;
        logic       rd_ok;
        cnt = 5'(model_q.size());
        wr_en = w;
        wr_data = d;
        rd_en = r;
        #1;
        exp_flags = {cnt == 5'd16, cnt == 5'd0, cnt >= m_afull, cnt <= m_aempty,
                     w && (cnt == 5'd16), r && (cnt == 5'd0)};
        check_eq(16'({full, empty, almost_full, almost_empty, overflow, underflow}),
                 16'(exp_flags), "flags before the edge");
        wr_ok = w && (cnt != 5'd16);
        rd_ok = r && (cnt != 5'd0);
        if (rd_ok) exp_rd = model_q.pop_front();
        if (wr_ok) model_q.push_back(d);
        if (w && !wr_ok && m_ovf != 8'hff) m_ovf = m_ovf + 8'd1;
        if (r && !rd_ok && m_unf != 8'hff) m_unf = m_unf + 8'd1;
        @(posedge clk);
        #2;
        check_eq(16'(rd_data), 16'(exp_rd), "read data");
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
        wr_en = 1'b0;
        rd_en = 1'b0;
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(posedge clk);
        #2;
        reg_wr = 1'b0;
        if (addr == reg_afull) m_afull = data[4:0];
        if (addr == reg_aempty) m_aempty = data[4:0];
        if (addr == reg_errors) begin
            m_ovf = '0;
            m_unf = '0;
        end
    endtask

    task automatic check_regs();
        logic [4:0]  cnt;
        logic [15:0] exp_status;
        cnt = 5'(model_q.size());
        exp_status = '0;
        exp_status[4:0] = cnt;
        exp_status[8] = (cnt == 5'd0);
        exp_status[9] = (cnt <= m_aempty);
        exp_status[10] = (cnt >= m_afull);
        exp_status[11] = (cnt == 5'd16);
        reg_addr = reg_afull;
        #1 check_eq(reg_rdata, 16'(m_afull), "almost-full threshold");
        reg_addr = reg_aempty;
        #1 check_eq(reg_rdata, 16'(m_aempty), "almost-empty threshold");
        reg_addr = reg_status;
        #1 check_eq(reg_rdata, exp_status, "status word");
        reg_addr = reg_errors;
        #1 check_eq(reg_rdata, {m_unf, m_ovf}, "error counters");
    endtask

    // Reads until the DUT reports empty, checking every byte on the way
    task automatic drain_fifo(input int limit);
        int n;
        n = 0;
        while (!empty) begin
            if (n >= limit) begin
                $display("Timeout at %0t ns: FIFO still not empty after %0d reads", $time, n);
                $display("Test failed");
                $fatal(1, "Drain timeout");
            end
            run_cycle(1'b0, 8'h00, 1'b1);
            n++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        reg_wr = 1'b0;
        wr_data = '0;
        reg_addr = '0;
        reg_wdata = '0;
        seed = 32'hf6e8005a;
        m_afull = afull_reset;
        m_aempty = aempty_reset;
        m_ovf = '0;
        m_unf = '0;
        exp_rd = '0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;

        // ******************************
        // Reset state and random traffic
        // ******************************
        check_regs();
        run_cycle(1'b0, 8'h00, 1'b0);
        for (int i = 0; i < 2000; i++) begin
            rnd = $random(seed);
            run_cycle(rnd[0], rnd[15:8], rnd[1]);
            if (i % 100 == 99) check_regs();
        end

        // ******************************
        // Overflow and underflow
        // ******************************
        drain_fifo(32);
        reg_write(reg_errors, 16'h0000);
        for (int i = 0; i < 21; i++) begin
            rnd = $random(seed);
            run_cycle(1'b1, rnd[7:0], 1'b0);    // Five writes past full
        end
        check_regs();
        drain_fifo(32);
        for (int i = 0; i < 4; i++) run_cycle(1'b0, 8'h00, 1'b1);
        check_regs();
        reg_write(reg_errors, 16'hffff);
        check_regs();

        // Random thresholds with a short burst of traffic each
        for (int t = 0; t < 20; t++) begin
            rnd = $random(seed);
            reg_write(reg_afull, rnd[15:0]);
            reg_write(reg_aempty, rnd[31:16]);
            check_regs();
            for (int i = 0; i < 30; i++) begin
                rnd = $random(seed);
                run_cycle(rnd[0] | rnd[2], rnd[15:8], rnd[1]);
            end
            check_regs();
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* build.f */
fifo_pkg.sv
fifo_cfg_if.sv
sync_fifo.sv
fifo_regs.sv
fifo_buffer_top.sv
fifo_buffer_asserts.sv
tb_fifo_buffer.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fifo_buffer
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed
FAIL_MSG  ?= Test failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a pass line, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
